// ==== hdl/sica_pkg.sv ====
package sica_pkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        NORM,
        DIFF,
        REPORT,
        COMPLETE
    } sica_state_t;

    // Operand source for a norm run
    typedef enum logic {
        NORM_COLUMN,
        NORM_DIFF
    } norm_mode_t;

    // 1/K for the CORDIC gain, about 0.60725 in Q1.15
    localparam logic [15:0] CORDIC_GAIN_INV = 16'd19898;

    // Headroom above the sample width for chained magnitudes
    localparam int GUARD_BITS = 2;

endpackage

// ==== hdl/cordic_vectoring.sv ====
`timescale 1ns/1ns

module cordic_vectoring #(
    parameter int DATA_WIDTH    = 16,
    parameter int CORDIC_STAGES = 16
) (
    input  logic                                          clk,
    input  logic                                          nreset,
    input  logic                                          cordic_start,
    input  logic signed [DATA_WIDTH+sica_pkg::GUARD_BITS:0] x_in,
    input  logic signed [DATA_WIDTH+sica_pkg::GUARD_BITS:0] y_in,
    output logic                                          cordic_done,
    output logic [DATA_WIDTH+sica_pkg::GUARD_BITS-1:0]    magnitude
);

    localparam int MW   = DATA_WIDTH + sica_pkg::GUARD_BITS;
    localparam int XW   = MW + 1;
    // Fraction bits soak up shift truncation
    localparam int FRAC = 4;
    localparam int PAD  = 2;
    localparam int IW   = XW + PAD + FRAC;
    localparam logic [IW+15:0] ROUND = 1 << (14 + FRAC);

    logic                              busy;
    logic [$clog2(CORDIC_STAGES)-1:0]  iter;
    logic signed [XW-1:0]              x_abs;
    logic signed [IW-1:0]              x;
    logic signed [IW-1:0]              y;
    logic [IW+15:0]                    scaled;

    // Fold into the right half-plane
    assign x_abs = x_in[XW-1] ? -x_in : x_in;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            busy        <= 1'b0;
            iter        <= '0;
            cordic_done <= 1'b0;
        end else begin
            cordic_done <= 1'b0;
            if (cordic_start) begin
                busy <= 1'b1;
                iter <= '0;
            end else if (busy) begin
                iter <= iter + 1'b1;
                if (iter == CORDIC_STAGES - 1) begin
                    busy        <= 1'b0;
                    cordic_done <= 1'b1;
                end
            end
        end
    end

    // Micro-rotations drive y toward zero
    always_ff @(posedge clk) begin
        if (cordic_start) begin
            x <= {{PAD{x_abs[XW-1]}}, x_abs, {FRAC{1'b0}}};
            y <= {{PAD{y_in[XW-1]}}, y_in, {FRAC{1'b0}}};
        end else if (busy) begin
            if (y[IW-1]) begin
                x <= x - (y >>> iter);
                y <= y + (x >>> iter);
            end else begin
                x <= x + (y >>> iter);
                y <= y - (x >>> iter);
            end
        end
    end

    // Gain compensation, rounded back to integer
    assign scaled    = $unsigned(x) * sica_pkg::CORDIC_GAIN_INV + ROUND;
    assign magnitude = scaled[15+FRAC +: MW];

    assert property (@(posedge clk) disable iff (!nreset) cordic_start |-> !busy);

endmodule

// ==== hdl/vector_norm.sv ====
`timescale 1ns/1ns

module vector_norm #(
    parameter int DATA_WIDTH    = 16,
    parameter int DIM           = 4,
    parameter int CORDIC_STAGES = 16
) (
    input  logic                                        clk,
    input  logic                                        nreset,
    input  logic                                        norm_start,
    input  logic signed [DATA_WIDTH:0]                  operand,
    output logic [$clog2(DIM)-1:0]                      elem_idx,
    output logic                                        norm_done,
    output logic [DATA_WIDTH+sica_pkg::GUARD_BITS-1:0]  norm_value
);

    localparam int MW = DATA_WIDTH + sica_pkg::GUARD_BITS;

    logic                      first;
    logic                      cordic_start;
    logic                      cordic_done;
    logic [MW-1:0]             magnitude;
    logic [MW-1:0]             acc;
    logic [DATA_WIDTH:0]       op_abs;
    logic signed [MW:0]        cordic_x;
    logic signed [MW:0]        cordic_y;

    assign op_abs   = operand[DATA_WIDTH] ? -operand : operand;
    assign cordic_x = {1'b0, acc};
    assign cordic_y = {{sica_pkg::GUARD_BITS{operand[DATA_WIDTH]}}, operand};

    always_ff @(posedge clk) begin
        if (!nreset) begin
            first        <= 1'b0;
            elem_idx     <= '0;
            cordic_start <= 1'b0;
            norm_done    <= 1'b0;
        end else begin
            cordic_start <= 1'b0;
            norm_done    <= 1'b0;
            if (norm_start) begin
                first    <= 1'b1;
                elem_idx <= '0;
            end else if (first) begin
                first        <= 1'b0;
                elem_idx     <= elem_idx + 1'b1;
                cordic_start <= 1'b1;
            end else if (cordic_done) begin
                if (elem_idx == DIM - 1) begin
                    norm_done <= 1'b1;
                end else begin
                    elem_idx     <= elem_idx + 1'b1;
                    cordic_start <= 1'b1;
                end
            end
        end
    end

    // Running norm of the elements seen so far
    always_ff @(posedge clk) begin
        if (first) begin
            acc <= MW'(op_abs);
        end else if (cordic_done) begin
            acc <= magnitude;
        end
    end

    assign norm_value = acc;

    cordic_vectoring #(
        .DATA_WIDTH    (DATA_WIDTH),
        .CORDIC_STAGES (CORDIC_STAGES)
    ) cordic_i (
        .clk          (clk),
        .nreset       (nreset),
        .cordic_start (cordic_start),
        .x_in         (cordic_x),
        .y_in         (cordic_y),
        .cordic_done  (cordic_done),
        .magnitude    (magnitude)
    );

    assert property (@(posedge clk) disable iff (!nreset) elem_idx < DIM);

endmodule

// ==== hdl/column_buffer.sv ====
`timescale 1ns/1ns

module column_buffer #(
    parameter int DATA_WIDTH = 16,
    parameter int DIM        = 4
) (
    input  logic                          clk,
    input  logic                          nreset,
    input  sica_pkg::norm_mode_t          norm_mode,
    input  logic [$clog2(DIM)-1:0]        elem_idx,
    input  logic signed [DATA_WIDTH-1:0]  rd_data,
    input  logic                          col_advance,
    output logic signed [DATA_WIDTH:0]    operand
);

    logic signed [DATA_WIDTH-1:0] cur_col  [DIM];
    logic signed [DATA_WIDTH-1:0] prev_col [DIM];
    logic signed [DATA_WIDTH:0]   cur_ext;
    logic signed [DATA_WIDTH:0]   prev_ext;

    // Snoop the element reads of a column norm run
    always_ff @(posedge clk) begin
        if (norm_mode == sica_pkg::NORM_COLUMN) cur_col[elem_idx] <= rd_data;
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            for (int i = 0; i < DIM; i++) begin
                prev_col[i] <= '0;
            end
        end else if (col_advance) begin
            prev_col <= cur_col;
        end
    end

    assign cur_ext  = {rd_data[DATA_WIDTH-1], rd_data};
    assign prev_ext = {prev_col[elem_idx][DATA_WIDTH-1], prev_col[elem_idx]};

    // One extra bit keeps the difference exact
    assign operand = (norm_mode == sica_pkg::NORM_DIFF) ? cur_ext - prev_ext : cur_ext;

endmodule

// ==== hdl/sample_store.sv ====
`timescale 1ns/1ns

module sample_store #(
    parameter int DATA_WIDTH = 16,
    parameter int DIM        = 4,
    parameter int COLS       = 4
) (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [$clog2(COLS*DIM)-1:0]   wr_addr,
    input  logic signed [DATA_WIDTH-1:0]  wr_data,
    input  logic [$clog2(COLS)-1:0]       col_idx,
    input  logic [$clog2(DIM)-1:0]        elem_idx,
    output logic signed [DATA_WIDTH-1:0]  rd_data
);

    localparam int DEPTH = COLS * DIM;
    localparam int AW    = $clog2(DEPTH);

    logic signed [DATA_WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]                rd_addr;

    // Words land column by column
    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    assign rd_addr = AW'(col_idx * DIM + elem_idx);
    assign rd_data = mem[rd_addr];

endmodule

// ==== hdl/load_counter.sv ====
`timescale 1ns/1ns

module load_counter #(
    parameter int DIM  = 4,
    parameter int COLS = 4
) (
    input  logic                          clk,
    input  logic                          nreset,
    input  logic                          load_en,
    input  logic                          serial_z_valid,
    input  logic                          load_data,
    output logic                          wr_en,
    output logic [$clog2(COLS*DIM)-1:0]   wr_addr,
    output logic                          store_full
);

    localparam int DEPTH = COLS * DIM;

    assign wr_en = load_en && serial_z_valid && load_data;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            wr_addr    <= '0;
            store_full <= 1'b0;
        end else if (wr_en) begin
            if (wr_addr == DEPTH - 1) begin
                wr_addr    <= '0;
                store_full <= 1'b1;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // Relies on the controller dropping load_en once full
    assert property (@(posedge clk) disable iff (!nreset)
        !(wr_en && store_full));

endmodule

// ==== hdl/sica_fsm.sv ====
`timescale 1ns/1ns

module sica_fsm #(
    parameter int DATA_WIDTH = 16,
    parameter int COLS       = 4,
    parameter int THRESHOLD  = 32
) (
    input  logic                                        clk,
    input  logic                                        nreset,
    input  logic                                        sica_start,
    input  logic                                        store_full,
    input  logic                                        norm_done,
    input  logic [DATA_WIDTH+sica_pkg::GUARD_BITS-1:0]  norm_value,
    output logic                                        load_en,
    output logic [$clog2(COLS)-1:0]                     col_idx,
    output sica_pkg::norm_mode_t                        norm_mode,
    output logic                                        norm_start,
    output logic                                        col_advance,
    output logic [DATA_WIDTH+sica_pkg::GUARD_BITS-1:0]  col_norm,
    output logic                                        col_norm_valid,
    output logic                                        col_close,
    output logic                                        sica_complete
);

    sica_pkg::sica_state_t state;

    // Gate on store_full so no word slips in after the last one
    assign load_en       = (state == sica_pkg::LOAD) && !store_full;
    assign sica_complete = (state == sica_pkg::COMPLETE);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state          <= sica_pkg::IDLE;
            col_idx        <= '0;
            norm_mode      <= sica_pkg::NORM_COLUMN;
            norm_start     <= 1'b0;
            col_advance    <= 1'b0;
            col_norm_valid <= 1'b0;
            col_close      <= 1'b0;
        end else begin
            norm_start     <= 1'b0;
            col_advance    <= 1'b0;
            col_norm_valid <= 1'b0;
            case (state)
                sica_pkg::IDLE: begin
                    if (sica_start) state <= sica_pkg::LOAD;
                end
                sica_pkg::LOAD: begin
                    if (store_full) begin
                        norm_mode  <= sica_pkg::NORM_COLUMN;
                        norm_start <= 1'b1;
                        state      <= sica_pkg::NORM;
                    end
                end
                sica_pkg::NORM: begin
                    if (norm_done) begin
                        if (col_idx == '0) begin
                            // Nothing to compare the first column against
                            col_close      <= 1'b0;
                            col_norm_valid <= 1'b1;
                            col_advance    <= 1'b1;
                            state          <= sica_pkg::REPORT;
                        end else begin
                            norm_mode  <= sica_pkg::NORM_DIFF;
                            norm_start <= 1'b1;
                            state      <= sica_pkg::DIFF;
                        end
                    end
                end
                sica_pkg::DIFF: begin
                    if (norm_done) begin
                        col_close      <= (norm_value <= THRESHOLD);
                        col_norm_valid <= 1'b1;
                        col_advance    <= 1'b1;
                        state          <= sica_pkg::REPORT;
                    end
                end
                sica_pkg::REPORT: begin
                    norm_mode <= sica_pkg::NORM_COLUMN;
                    if (col_idx == COLS - 1) begin
                        state <= sica_pkg::COMPLETE;
                    end else begin
                        col_idx    <= col_idx + 1'b1;
                        norm_start <= 1'b1;
                        state      <= sica_pkg::NORM;
                    end
                end
                sica_pkg::COMPLETE: state <= sica_pkg::COMPLETE;
                default: state <= sica_pkg::IDLE;
            endcase
        end
    end

    // Column norm is held through the difference run
    always_ff @(posedge clk) begin
        if (state == sica_pkg::NORM && norm_done) col_norm <= norm_value;
    end

    assert property (@(posedge clk) disable iff (!nreset)
        col_norm_valid |-> state == sica_pkg::REPORT);

endmodule

// ==== hdl/sica_top.sv ====
`timescale 1ns/1ns

module sica_top #(
    parameter int DATA_WIDTH    = 16,
    parameter int DIM           = 4,
    parameter int COLS          = 4,
    parameter int CORDIC_STAGES = 16,
    parameter int THRESHOLD     = 32
) (
    input  logic                                        clk,
    input  logic                                        nreset,
    input  logic                                        sica_start,
    input  logic signed [DATA_WIDTH-1:0]                serial_z_in,
    input  logic                                        serial_z_valid,
    input  logic                                        load_data,
    output logic [DATA_WIDTH+sica_pkg::GUARD_BITS-1:0]  col_norm,
    output logic                                        col_norm_valid,
    output logic                                        col_close,
    output logic [$clog2(COLS)-1:0]                     col_idx,
    output logic                                        sica_complete
);

    localparam int AW = $clog2(COLS * DIM);
    localparam int EW = $clog2(DIM);
    localparam int MW = DATA_WIDTH + sica_pkg::GUARD_BITS;

    logic                          load_en;
    logic                          store_full;
    logic                          wr_en;
    logic [AW-1:0]                 wr_addr;
    logic signed [DATA_WIDTH-1:0]  rd_data;
    logic [EW-1:0]                 elem_idx;
    sica_pkg::norm_mode_t          norm_mode;
    logic signed [DATA_WIDTH:0]    operand;
    logic                          norm_start;
    logic                          norm_done;
    logic [MW-1:0]                 norm_value;
    logic                          col_advance;

    sica_fsm #(
        .DATA_WIDTH (DATA_WIDTH),
        .COLS       (COLS),
        .THRESHOLD  (THRESHOLD)
    ) fsm_i (
        .clk            (clk),
        .nreset         (nreset),
        .sica_start     (sica_start),
        .store_full     (store_full),
        .norm_done      (norm_done),
        .norm_value     (norm_value),
        .load_en        (load_en),
        .col_idx        (col_idx),
        .norm_mode      (norm_mode),
        .norm_start     (norm_start),
        .col_advance    (col_advance),
        .col_norm       (col_norm),
        .col_norm_valid (col_norm_valid),
        .col_close      (col_close),
        .sica_complete  (sica_complete)
    );

    load_counter #(
        .DIM  (DIM),
        .COLS (COLS)
    ) load_i (
        .clk            (clk),
        .nreset         (nreset),
        .load_en        (load_en),
        .serial_z_valid (serial_z_valid),
        .load_data      (load_data),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .store_full     (store_full)
    );

    sample_store #(
        .DATA_WIDTH (DATA_WIDTH),
        .DIM        (DIM),
        .COLS       (COLS)
    ) store_i (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (serial_z_in),
        .col_idx  (col_idx),
        .elem_idx (elem_idx),
        .rd_data  (rd_data)
    );

    column_buffer #(
        .DATA_WIDTH (DATA_WIDTH),
        .DIM        (DIM)
    ) colbuf_i (
        .clk         (clk),
        .nreset      (nreset),
        .norm_mode   (norm_mode),
        .elem_idx    (elem_idx),
        .rd_data     (rd_data),
        .col_advance (col_advance),
        .operand     (operand)
    );

    vector_norm #(
        .DATA_WIDTH    (DATA_WIDTH),
        .DIM           (DIM),
        .CORDIC_STAGES (CORDIC_STAGES)
    ) norm_i (
        .clk        (clk),
        .nreset     (nreset),
        .norm_start (norm_start),
        .operand    (operand),
        .elem_idx   (elem_idx),
        .norm_done  (norm_done),
        .norm_value (norm_value)
    );

    // A norm result only arrives while the controller waits for one
    assert property (@(posedge clk) disable iff (!nreset)
        norm_done |-> fsm_i.state inside {sica_pkg::NORM, sica_pkg::DIFF});

endmodule

// ==== testbench/sica_tb.sv ====
`timescale 1ns/1ns

module sica_tb;

    localparam int DATA_WIDTH    = 16;
    localparam int DIM           = 4;
    localparam int COLS          = 4;
    localparam int CORDIC_STAGES = 16;
    localparam int THRESHOLD     = 32;
    localparam int NORM_TOL      = 4;
    localparam logic [31:0] SEED = 32'h3fd4_d6ec;
    localparam int MAX_GAP       = 3;
    localparam int NUM_SAMPLES   = COLS * DIM;
    localparam int LOAD_WORDS    = NUM_SAMPLES + 2;
    localparam int CASE_WORDS    = NUM_SAMPLES + 2 + 2 * COLS;
    localparam int TIMEOUT_CYCLES =
        2 * (LOAD_WORDS * (MAX_GAP + 2) + COLS * 2 * DIM * (CORDIC_STAGES + 4));

    logic                                  clk;
    logic                                  nreset;
    logic                                  sica_start;
    logic signed [DATA_WIDTH-1:0]          serial_z_in;
    logic                                  serial_z_valid;
    logic                                  load_data;
    logic [DATA_WIDTH+1:0]                 col_norm;
    logic                                  col_norm_valid;
    logic                                  col_close;
    logic [$clog2(COLS)-1:0]               col_idx;
    logic                                  sica_complete;

    logic [15:0] cases_mem [CASE_WORDS];
    int          errors;
    int          cycles;
    int          got_norm[$];
    int          got_close[$];
    int          got_idx[$];
    int          last_pulse_cycle;
    int          complete_cycle;
    logic        complete_seen;
    logic        complete_dropped;

    sica_top #(
        .DATA_WIDTH    (DATA_WIDTH),
        .DIM           (DIM),
        .COLS          (COLS),
        .CORDIC_STAGES (CORDIC_STAGES),
        .THRESHOLD     (THRESHOLD)
    ) dut_i (
        .clk            (clk),
        .nreset         (nreset),
        .sica_start     (sica_start),
        .serial_z_in    (serial_z_in),
        .serial_z_valid (serial_z_valid),
        .load_data      (load_data),
        .col_norm       (col_norm),
        .col_norm_valid (col_norm_valid),
        .col_close      (col_close),
        .col_idx        (col_idx),
        .sica_complete  (sica_complete)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string test_name, input int expected, input int actual,
                               input int tol);
        int diff;
        diff = expected - actual;
        if (diff < 0) diff = -diff;
        if (diff > tol) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", test_name, expected, actual);
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic offer_word(input logic [15:0] word, input logic valid, input logic ld);
        @(posedge clk);
        #2;
        serial_z_in    = word;
        serial_z_valid = valid;
        load_data      = ld;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (nreset) begin
            if (col_norm_valid) begin
                got_norm.push_back(int'(col_norm));
                got_close.push_back(int'(col_close));
                got_idx.push_back(int'(col_idx));
                last_pulse_cycle = cycles;
            end
            if (sica_complete && !complete_seen) begin
                complete_seen  = 1'b1;
                complete_cycle = cycles;
            end
            if (complete_seen && !sica_complete) complete_dropped = 1'b1;
        end
    end

    initial begin
        int gap;
        clk              = 1'b0;
        nreset           = 1'b0;
        sica_start       = 1'b0;
        serial_z_in      = '0;
        serial_z_valid   = 1'b0;
        load_data        = 1'b0;
        errors           = 0;
        cycles           = 0;
        last_pulse_cycle = -1;
        complete_cycle   = -1;
        complete_seen    = 1'b0;
        complete_dropped = 1'b0;
        void'($urandom(SEED));

        $readmemh("testbench/sica_cases.txt", cases_mem);
        if ($isunknown(cases_mem[0])) begin
            errors++;
            $display("Cases file testbench/sica_cases.txt could not be read");
        end

        repeat (2) @(posedge clk);
        #2;
        nreset = 1'b1;
        @(negedge clk);
        // Unknown counts as set
        check_value("reset col_norm_valid", 0, int'(col_norm_valid !== 1'b0), 0);
        check_value("reset sica_complete", 0, int'(sica_complete !== 1'b0), 0);

        @(posedge clk);
        #2;
        sica_start = 1'b1;
        @(posedge clk);
        #2;
        sica_start = 1'b0;

        for (int i = 0; i < NUM_SAMPLES; i++) begin
            gap = $urandom % (MAX_GAP + 1);
            repeat (gap) offer_word(16'h0000, 1'b0, 1'b0);
            // Junk with load_data low, then junk with valid low
            if (i == 5) offer_word(cases_mem[NUM_SAMPLES], 1'b1, 1'b0);
            if (i == 11) offer_word(cases_mem[NUM_SAMPLES+1], 1'b0, 1'b1);
            offer_word(cases_mem[i], 1'b1, 1'b1);
        end
        offer_word(16'h0000, 1'b0, 1'b0);

        wait (sica_complete);
        repeat (200) @(posedge clk);

        check_value("column report count", COLS, got_norm.size(), 0);
        for (int c = 0; c < COLS && c < got_norm.size(); c++) begin
            check_value($sformatf("col %0d index", c), c, got_idx[c], 0);
            check_value($sformatf("col %0d norm", c),
                        int'(cases_mem[NUM_SAMPLES+2+c]), got_norm[c], NORM_TOL);
            check_value($sformatf("col %0d close", c),
                        int'(cases_mem[NUM_SAMPLES+2+COLS+c]), got_close[c], 0);
        end
        check_value("completion cycle", last_pulse_cycle + 1, complete_cycle, 0);
        if (complete_dropped) begin
            errors++;
            $display("sica_complete fell before the end of the run");
        end

        $display("Run finished with %0d errors over %0d column reports",
                 errors, got_norm.size());
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sica_top.f ====
hdl/sica_pkg.sv
hdl/cordic_vectoring.sv
hdl/vector_norm.sv
hdl/column_buffer.sv
hdl/sample_store.sv
hdl/load_counter.sv
hdl/sica_fsm.sv
hdl/sica_top.sv
testbench/sica_tb.sv

// ==== Bender.yml ====
package:
  name: sica

sources:
  - hdl/sica_pkg.sv
  - hdl/cordic_vectoring.sv
  - hdl/vector_norm.sv
  - hdl/column_buffer.sv
  - hdl/sample_store.sv
  - hdl/load_counter.sv
  - hdl/sica_fsm.sv
  - hdl/sica_top.sv
  - target: test
    files:
      - testbench/sica_tb.sv

// ==== testbench/sica_cases.txt ====
// Hex words: 16 samples in column order, 2 junk words, 4 expected norms, 4 close flags
// Samples are 16-bit two's complement, norms are rounded Euclidean norms
0064 00c8 0190 00c8
006e 00c8 0190 00c8
fed4 04b0 0190 0000
fed4 04b0 01a4 0000
// Junk words, never accepted
7fff 8001
// Expected column norms 500, 502, 1300, 1306
01f4 01f6 0514 051a
// Expected close flags
0000 0001 0000 0001
